/* src/prefetch_pkg.sv */
// ====================
// Shared widths, opcodes, FSM encodings and the instruction word type
// Referenced by scoped name from the prefetch RTL and testbench
// ====================

package prefetch_pkg;

    // Datapath widths
    localparam int XLEN   = 32;
    localparam int HALF_W = 16;

    // Base opcodes produced by the RV32C expander
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // Realigner FSM encodings
    localparam int         ST_W            = 3;
    localparam logic [2:0] ST_IDLE         = 3'd0;
    localparam logic [2:0] ST_FETCH_FIRST  = 3'd1;
    localparam logic [2:0] ST_FETCH_SECOND = 3'd2;
    localparam logic [2:0] ST_DRAIN        = 3'd3;
    localparam logic [2:0] ST_DELIVER      = 3'd4;

    // Two halfwords of a fetched word, upper half first
    typedef struct packed {
        logic [HALF_W-1:0] hi;
        logic [HALF_W-1:0] lo;
    } half_pair_t;

    // One 32-bit word seen either whole or as two halfwords
    typedef union packed {
        logic [XLEN-1:0] full;
        half_pair_t      halves;
    } instr_word_u;

endpackage

/* src/realign.sv */
// ====================
// Word fetch and halfword realignment for the prefetch stage
// Serves IF requests from a one-word buffer or from the I-cache
// ====================
`timescale 1ns/1ps

module realign (
    input  logic                           clk,
    input  logic                           rst_n_i,
    // Fetch unit side
    input  logic                           if_req_i,
    input  logic [prefetch_pkg::XLEN-1:0]  if_addr_i,
    input  logic                           if_kill_i,
    // Instruction cache side
    output logic                           icache_req_o,
    output logic [prefetch_pkg::XLEN-1:0]  icache_addr_o,
    input  logic                           icache_ack_i,
    input  prefetch_pkg::instr_word_u      icache_data_i,
    // Towards the expander
    output logic                           ralgn_ack_o,
    output prefetch_pkg::instr_word_u      ralgn_instr_o
);

    logic [prefetch_pkg::ST_W-1:0]   state_q;
    logic                            buf_valid_q;
    prefetch_pkg::instr_word_u       buf_q;
    logic [prefetch_pkg::XLEN-1:2]   buf_word_q;
    logic [prefetch_pkg::XLEN-1:0]   fetch_addr_q;
    logic [prefetch_pkg::HALF_W-1:0] hi_save_q;
    logic                            pc_hi_q;
    prefetch_pkg::instr_word_u       instr_q;

    logic word_hit;
    logic buf_needs_next;
    logic new_needs_next;

    // Picks the half at PC bit 1, zero-extended when it is compressed
    function automatic prefetch_pkg::instr_word_u select_half(
        input prefetch_pkg::instr_word_u w,
        input logic                      hi_sel
    );
        logic [prefetch_pkg::HALF_W-1:0] h;
        prefetch_pkg::instr_word_u       r;
        h = hi_sel ? w.halves.hi : w.halves.lo;
        if (h[1:0] != 2'b11) begin
            r.full = {{prefetch_pkg::HALF_W{1'b0}}, h};
        end else begin
            r = w;
        end
        return r;
    endfunction

    // Buffered word covers the requested PC
    assign word_hit = buf_valid_q && (buf_word_q == if_addr_i[prefetch_pkg::XLEN-1:2]);

    // Upper half starts a 32-bit instruction, second word required
    assign buf_needs_next = if_addr_i[1] && (buf_q.halves.hi[1:0] == 2'b11);
    assign new_needs_next = pc_hi_q && (icache_data_i.halves.hi[1:0] == 2'b11);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q     <= prefetch_pkg::ST_IDLE;
            buf_valid_q <= 1'b0;
        end else begin
            case (state_q)
                prefetch_pkg::ST_IDLE: begin
                    if (if_kill_i) begin
                        buf_valid_q <= 1'b0;
                    end else if (if_req_i) begin
                        pc_hi_q <= if_addr_i[1];
                        if (word_hit && !buf_needs_next) begin
                            // Served straight from the buffer
                            instr_q <= select_half(buf_q, if_addr_i[1]);
                            state_q <= prefetch_pkg::ST_DELIVER;
                        end else begin
                            // PC word first, next word follows for a crossing instruction
                            fetch_addr_q <= {if_addr_i[prefetch_pkg::XLEN-1:2], 2'b00};
                            state_q      <= prefetch_pkg::ST_FETCH_FIRST;
                        end
                    end
                end

                prefetch_pkg::ST_FETCH_FIRST: begin
                    if (if_kill_i) begin
                        buf_valid_q <= 1'b0;
                        state_q     <= icache_ack_i ? prefetch_pkg::ST_IDLE
                                                    : prefetch_pkg::ST_DRAIN;
                    end else if (icache_ack_i) begin
                        buf_q       <= icache_data_i;
                        buf_word_q  <= fetch_addr_q[prefetch_pkg::XLEN-1:2];
                        buf_valid_q <= 1'b1;
                        if (new_needs_next) begin
                            hi_save_q    <= icache_data_i.halves.hi;
                            fetch_addr_q <= fetch_addr_q + prefetch_pkg::XLEN'(4);
                            state_q      <= prefetch_pkg::ST_FETCH_SECOND;
                        end else begin
                            instr_q <= select_half(icache_data_i, pc_hi_q);
                            state_q <= prefetch_pkg::ST_DELIVER;
                        end
                    end
                end

                prefetch_pkg::ST_FETCH_SECOND: begin
                    if (if_kill_i) begin
                        buf_valid_q <= 1'b0;
                        state_q     <= icache_ack_i ? prefetch_pkg::ST_IDLE
                                                    : prefetch_pkg::ST_DRAIN;
                    end else if (icache_ack_i) begin
                        // Join saved upper half with lower half of the next word
                        instr_q.full <= {icache_data_i.halves.lo, hi_save_q};
                        buf_q        <= icache_data_i;
                        buf_word_q   <= fetch_addr_q[prefetch_pkg::XLEN-1:2];
                        buf_valid_q  <= 1'b1;
                        state_q      <= prefetch_pkg::ST_DELIVER;
                    end
                end

                // Stale reply still owed by the cache, drop it
                prefetch_pkg::ST_DRAIN: begin
                    buf_valid_q <= 1'b0;
                    if (icache_ack_i) begin
                        state_q <= prefetch_pkg::ST_IDLE;
                    end
                end

                prefetch_pkg::ST_DELIVER: begin
                    if (if_kill_i) begin
                        buf_valid_q <= 1'b0;
                    end
                    state_q <= prefetch_pkg::ST_IDLE;
                end

                default: begin
                    state_q <= prefetch_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Request held high while any cache reply is outstanding
    assign icache_req_o  = (state_q == prefetch_pkg::ST_FETCH_FIRST)
                        || (state_q == prefetch_pkg::ST_FETCH_SECOND)
                        || (state_q == prefetch_pkg::ST_DRAIN);
    assign icache_addr_o = fetch_addr_q;

    assign ralgn_ack_o   = (state_q == prefetch_pkg::ST_DELIVER);
    assign ralgn_instr_o = instr_q;

endmodule

/* src/decompress.sv */
// ====================
// Combinational RV32C subset expander
// Wide words pass through, unknown compressed ones become zero
// ====================
`timescale 1ns/1ps

module decompress (
    input  prefetch_pkg::instr_word_u      instr_i,
    output logic [prefetch_pkg::XLEN-1:0]  instr_o,
    output logic                           is_comp_o
);

    logic [prefetch_pkg::HALF_W-1:0] c;
    logic [prefetch_pkg::XLEN-1:0]   expanded;

    // Common C fields
    logic [4:0] rd_full;
    logic [4:0] rs2_full;
    logic [4:0] rd_p;
    logic [4:0] rs1_p;
    logic [5:0] imm6;
    logic [6:0] lw_off;

    // Compressed encodings live in the low half
    assign c = instr_i.halves.lo;

    assign rd_full  = c[11:7];
    assign rs2_full = c[6:2];

    // Three-bit register fields map onto x8..x15
    assign rd_p  = {2'b01, c[4:2]};
    assign rs1_p = {2'b01, c[9:7]};

    // CI immediate, sign bit in c[12]
    assign imm6 = {c[12], c[6:2]};

    // CL/CS word offset, bits 6..0 with two zero low bits
    assign lw_off = {c[5], c[12:10], c[6], 2'b00};

    always_comb begin
        expanded = '0;
        case ({c[15:13], c[1:0]})
            // C.LW -> lw rd', off(rs1')
            5'b010_00: begin
                expanded = {5'b00000, lw_off, rs1_p, 3'b010, rd_p,
                            prefetch_pkg::OPC_LOAD};
            end
            // C.SW -> sw rs2', off(rs1')
            5'b110_00: begin
                expanded = {5'b00000, lw_off[6:5], rd_p, rs1_p, 3'b010,
                            lw_off[4:0], prefetch_pkg::OPC_STORE};
            end
            // C.ADDI and C.NOP -> addi rd, rd, imm
            5'b000_01: begin
                expanded = {{6{imm6[5]}}, imm6, rd_full, 3'b000, rd_full,
                            prefetch_pkg::OPC_OP_IMM};
            end
            // C.LI -> addi rd, x0, imm
            5'b010_01: begin
                expanded = {{6{imm6[5]}}, imm6, 5'd0, 3'b000, rd_full,
                            prefetch_pkg::OPC_OP_IMM};
            end
            // C.LUI -> lui rd, imm
            5'b011_01: begin
                // rd of x2 is C.ADDI16SP, zero imm is reserved
                if (rd_full != 5'd2 && imm6 != 6'd0) begin
                    expanded = {{14{imm6[5]}}, imm6, rd_full,
                                prefetch_pkg::OPC_LUI};
                end
            end
            // C.J -> jal x0, off
            5'b101_01: begin
                expanded = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                            c[5:3], c[12], {8{c[12]}}, 5'd0,
                            prefetch_pkg::OPC_JAL};
            end
            // C.MV and C.ADD, zero rs2 means a jump form
            5'b100_10: begin
                if (rs2_full != 5'd0) begin
                    if (c[12]) begin
                        expanded = {7'b0000000, rs2_full, rd_full, 3'b000,
                                    rd_full, prefetch_pkg::OPC_OP};
                    end else begin
                        expanded = {7'b0000000, rs2_full, 5'd0, 3'b000,
                                    rd_full, prefetch_pkg::OPC_OP};
                    end
                end
            end
            default: begin
                expanded = '0;
            end
        endcase
    end

    // Anything but 11 in the low bits is a 16-bit encoding
    assign is_comp_o = (c[1:0] != 2'b11);
    assign instr_o   = is_comp_o ? expanded : instr_i.full;

endmodule

/* src/prefetch.sv */
// ====================
// Prefetch stage top between IF and the I-cache
// ====================
`timescale 1ns/1ps

module prefetch (
    input  logic                           clk,
    input  logic                           rst_n_i,
    // Fetch unit side
    input  logic                           if_req_i,
    input  logic [prefetch_pkg::XLEN-1:0]  if_addr_i,
    input  logic                           if_kill_i,
    output logic                           if_ack_o,
    output logic [prefetch_pkg::XLEN-1:0]  if_instr_o,
    output logic                           if_comp_o,
    // Instruction cache side
    output logic                           icache_req_o,
    output logic [prefetch_pkg::XLEN-1:0]  icache_addr_o,
    input  logic                           icache_ack_i,
    input  logic [prefetch_pkg::XLEN-1:0]  icache_data_i
);

    logic                      ralgn_ack;
    prefetch_pkg::instr_word_u ralgn_instr;
    logic                      is_comp;
    logic                      comp_ack;

    realign u_realign (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .if_req_i      (if_req_i),
        .if_addr_i     (if_addr_i),
        .if_kill_i     (if_kill_i),
        .icache_req_o  (icache_req_o),
        .icache_addr_o (icache_addr_o),
        .icache_ack_i  (icache_ack_i),
        .icache_data_i (icache_data_i),
        .ralgn_ack_o   (ralgn_ack),
        .ralgn_instr_o (ralgn_instr)
    );

    // Expander sits on the delivery path, no clock
    decompress u_decompress (
        .instr_i   (ralgn_instr),
        .instr_o   (if_instr_o),
        .is_comp_o (is_comp)
    );

    // Compressed flag dropped under kill, shown only with the ack
    assign comp_ack  = is_comp & ~if_kill_i;
    assign if_ack_o  = ralgn_ack;
    assign if_comp_o = comp_ack & ralgn_ack;

endmodule

/* tests/prefetch_assertions.sv */
// ====================
// Protocol assertions bound onto the prefetch top level
// ====================
`timescale 1ns/1ps

module prefetch_assertions (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          if_ack_o,
    input logic                          if_comp_o,
    input logic                          icache_req_o,
    input logic [prefetch_pkg::XLEN-1:0] icache_addr_o,
    input logic                          icache_ack_i
);

    // Number of property failures so far
    int err_count = 0;

    // No delivery straight out of reset
    assert property (@(posedge clk) !rst_n_i |=> !if_ack_o)
        else begin
            $error("if_ack_o high in the cycle after reset");
            err_count++;
        end

    // Cache request held until the reply
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     icache_req_o && !icache_ack_i |=> icache_req_o)
        else begin
            $error("icache_req_o dropped before icache_ack_i");
            err_count++;
        end

    // Word-aligned cache address
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     icache_req_o |-> icache_addr_o[1:0] == 2'b00)
        else begin
            $error("icache_addr_o not word aligned");
            err_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n_i) if_comp_o |-> if_ack_o)
        else begin
            $error("if_comp_o high without if_ack_o");
            err_count++;
        end

endmodule

bind prefetch prefetch_assertions u_assertions (.*);

/* tests/prefetch_tb.sv */
// ====================
// Testbench for the prefetch stage with a random-latency I-cache model
// Runs a table of fetch requests and checks every delivered instruction
// ====================
`timescale 1ns/1ps

module prefetch_tb;

    localparam int MEM_WORDS = 16;
    localparam int N_TESTS   = 15;
    localparam int TIMEOUT   = 60;

    logic                          clk;
    logic                          rst_n_i;
    logic                          if_req_i;
    logic [prefetch_pkg::XLEN-1:0] if_addr_i;
    logic                          if_kill_i;
    logic                          if_ack_o;
    logic [prefetch_pkg::XLEN-1:0] if_instr_o;
    logic                          if_comp_o;
    logic                          icache_req_o;
    logic [prefetch_pkg::XLEN-1:0] icache_addr_o;
    logic                          icache_ack_i;
    logic [prefetch_pkg::XLEN-1:0] icache_data_i;

    // Cache contents and model state
    prefetch_pkg::instr_word_u     mem [0:MEM_WORDS-1];
    logic [31:0]                   lfsr;
    logic                          pend;
    int                            cnt;
    logic [prefetch_pkg::XLEN-1:0] pend_addr;
    int                            served;
    logic [prefetch_pkg::XLEN-1:0] served_addr [0:1];

    // Stimulus and expected values, one row per request
    string                         t_name  [0:N_TESTS-1];
    logic [prefetch_pkg::XLEN-1:0] t_addr  [0:N_TESTS-1];
    logic                          t_kill  [0:N_TESTS-1];
    logic [prefetch_pkg::XLEN-1:0] t_instr [0:N_TESTS-1];
    logic                          t_comp  [0:N_TESTS-1];
    int                            t_fetch [0:N_TESTS-1];

    int  waited;
    logic saw_req;

    prefetch u_dut (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .if_req_i      (if_req_i),
        .if_addr_i     (if_addr_i),
        .if_kill_i     (if_kill_i),
        .if_ack_o      (if_ack_o),
        .if_instr_o    (if_instr_o),
        .if_comp_o     (if_comp_o),
        .icache_req_o  (icache_req_o),
        .icache_addr_o (icache_addr_o),
        .icache_ack_i  (icache_ack_i),
        .icache_data_i (icache_data_i)
    );

    always #50 clk = ~clk;

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic fail_now();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_instr(input string name, input logic [prefetch_pkg::XLEN-1:0] exp,
                               input logic [prefetch_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %08h actual %08h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_comp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected comp %0b actual %0b", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_addr(input string name, input logic [prefetch_pkg::XLEN-1:0] exp,
                              input logic [prefetch_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected address %08h actual %08h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s expected %0d cache reads actual %0d", name, exp, act);
            fail_now();
        end
    endtask

    task automatic add_row(input int i, input string name, input logic [31:0] addr,
                           input logic kill, input logic [31:0] instr,
                           input logic comp, input int fetches);
        t_name[i]  = name;
        t_addr[i]  = addr;
        t_kill[i]  = kill;
        t_instr[i] = instr;
        t_comp[i]  = comp;
        t_fetch[i] = fetches;
    endtask

    // Cache model, replies 1 to 4 cycles after the request is seen
    always @(negedge clk) begin
        if (icache_ack_i) begin
            icache_ack_i = 1'b0;
        end else if (icache_req_o && !pend) begin
            pend      = 1'b1;
            pend_addr = icache_addr_o;
            cnt       = 1 + lfsr[0];
            lfsr      = lfsr_next(lfsr);
            cnt       = cnt + 2 * lfsr[0];
            lfsr      = lfsr_next(lfsr);
        end else if (pend) begin
            cnt = cnt - 1;
            if (cnt == 0) begin
                icache_data_i = mem[pend_addr[5:2]].full;
                icache_ack_i  = 1'b1;
                pend          = 1'b0;
                if (served < 2) begin
                    served_addr[served] = pend_addr;
                end
                served = served + 1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst_n_i = 1'b0;
        if_req_i = 1'b0;
        if_addr_i = '0;
        if_kill_i = 1'b0;
        icache_ack_i = 1'b0;
        icache_data_i = '0;
        lfsr = 32'h182a;
        pend = 1'b0;
        cnt = 0;
        served = 0;
        // Filler words are 32-bit encodings tagged with their index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i].full = {i[24:0], 7'b0010011};
        end
        mem[0].full = 32'h0050_0093;  // addi x1, x0, 5
        mem[1].full = 32'h147D_451D;  // c.addi x8,-1 | c.li x10,7
        mem[2].full = 32'hA021_6285;  // c.j +8 | c.lui x5,1
        mem[3].full = 32'h06B3_85B2;  // add x13 low half | c.mv x11,x12
        mem[4].full = 32'h94AA_00F7;  // c.add x9,x10 | add x13 high half
        mem[5].full = 32'hC488_4044;  // c.sw x10,8(x9) | c.lw x9,4(x8)
        mem[6].full = 32'h0001_0000;  // c.nop | illegal zero
        mem[7].full = 32'h1234_53B7;  // lui x7, 0x12345

        add_row(0,  "aligned_32",    32'd0,  1'b0, 32'h0050_0093, 1'b0, 1);
        add_row(1,  "c_li_lo",       32'd4,  1'b0, 32'h0070_0513, 1'b1, 1);
        add_row(2,  "c_addi_hi_buf", 32'd6,  1'b0, 32'hFFF4_0413, 1'b1, 0);
        add_row(3,  "c_lui_lo",      32'd8,  1'b0, 32'h0000_12B7, 1'b1, 1);
        add_row(4,  "c_j_hi_buf",    32'd10, 1'b0, 32'h0080_006F, 1'b1, 0);
        add_row(5,  "cross_32",      32'd14, 1'b0, 32'h00F7_06B3, 1'b0, 2);
        add_row(6,  "c_mv_lo",       32'd12, 1'b0, 32'h00C0_05B3, 1'b1, 1);
        add_row(7,  "c_add_hi",      32'd18, 1'b0, 32'h00A4_84B3, 1'b1, 1);
        add_row(8,  "c_lw_lo",       32'd20, 1'b0, 32'h0044_2483, 1'b1, 1);
        add_row(9,  "c_sw_hi_buf",   32'd22, 1'b0, 32'h00A4_A423, 1'b1, 0);
        add_row(10, "illegal_c",     32'd24, 1'b0, 32'h0000_0000, 1'b1, 1);
        add_row(11, "c_nop_hi_buf",  32'd26, 1'b0, 32'h0000_0013, 1'b1, 0);
        add_row(12, "kill_pending",  32'd28, 1'b1, 32'h0000_0000, 1'b0, 0);
        // Word 6 was buffered before the kill, so a refetch is expected
        add_row(13, "after_kill",    32'd26, 1'b0, 32'h0000_0013, 1'b1, 1);
        add_row(14, "aligned_lui",   32'd28, 1'b0, 32'h1234_53B7, 1'b0, 1);

        repeat (5) @(negedge clk);
        rst_n_i = 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            @(negedge clk);
            served    = 0;
            saw_req   = 1'b0;
            if_req_i  = 1'b1;
            if_addr_i = t_addr[t];
            waited    = 0;
            if (t_kill[t]) begin
                // Kill once the cache read is under way
                while (!icache_req_o) begin
                    @(negedge clk);
                    waited++;
                    if (waited > TIMEOUT) begin
                        $display("No cache request was issued before the kill");
                        fail_now();
                    end
                end
                if_kill_i = 1'b1;
                if_req_i  = 1'b0;
                @(negedge clk);
                if_kill_i = 1'b0;
                waited = 0;
                // DUT keeps its request up until the stale reply has drained
                while (icache_req_o) begin
                    @(negedge clk);
                    waited++;
                    if (waited > TIMEOUT) begin
                        $display("Killed cache read never drained");
                        fail_now();
                    end
                end
            end else begin
                while (!if_ack_o) begin
                    @(negedge clk);
                    saw_req = saw_req | icache_req_o;
                    waited++;
                    if (waited > TIMEOUT) begin
                        $display("No acknowledge arrived for request %s", t_name[t]);
                        fail_now();
                    end
                end
                check_instr(t_name[t], t_instr[t], if_instr_o);
                check_comp(t_name[t], t_comp[t], if_comp_o);
                check_count(t_name[t], t_fetch[t], served);
                if (t_fetch[t] == 0 && saw_req) begin
                    $display("Buffer hit %s still raised a cache request", t_name[t]);
                    fail_now();
                end
                // PC word is read first, then the word after it
                if (t_fetch[t] > 0) begin
                    check_addr({t_name[t], "_addr0"}, t_addr[t] & 32'hFFFF_FFFC,
                               served_addr[0]);
                end
                if (t_fetch[t] == 2) begin
                    check_addr({t_name[t], "_addr1"}, (t_addr[t] & 32'hFFFF_FFFC) + 32'd4,
                               served_addr[1]);
                end
                if_req_i = 1'b0;
            end
        end

        @(negedge clk);
        if (u_dut.u_assertions.err_count != 0) begin
            $display("Bound protocol assertions failed %0d times",
                     u_dut.u_assertions.err_count);
            fail_now();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* prefetch.f */
src/prefetch_pkg.sv
src/realign.sv
src/decompress.sv
src/prefetch.sv
tests/prefetch_assertions.sv
tests/prefetch_tb.sv
